// File: gshare_predictor.f
rtl/bp_pkg.sv
rtl/resolve_queue.sv
rtl/pattern_table.sv
rtl/counter_update.sv
rtl/gshare_predictor.sv
sim/bp_checker.sv
sim/tb_gshare.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_gshare
FILELIST := gshare_predictor.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -F -q "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/tb_gshare.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gshare import bp_pkg::*; ();

	// ========================================
	// run lengths in cycles
	// ========================================

	localparam int LEN_RESET = 4;
	localparam int LEN_T1 = 10;
	localparam int LEN_T2 = 30;
	localparam int LEN_T3 = 30;
	localparam int LEN_T4 = 50;
	localparam int LEN_T5 = 30;
	localparam int LEN_RAND = 3000;
	localparam int LEN_DRAIN = 20;
	localparam int TIMEOUT_CYC = LEN_RESET + LEN_T1 + LEN_T2 + LEN_T3 + LEN_T4 + LEN_T5
		+ LEN_RAND + LEN_DRAIN + 100;

	// fixed branches, all with distinct low index bits
	localparam logic [ADDR_BITS-1:0] ADDR_A = 32'h0000_0040;
	localparam logic [ADDR_BITS-1:0] ADDR_B = 32'h0000_0001;
	localparam logic [ADDR_BITS-1:0] ADDR_C = 32'h0000_0002;

	logic                                  clk = 1'b0;
	logic                                  rst;
	logic                                  en;
	logic [FETCH_SLOTS-1:0][ADDR_BITS-1:0] fetch_addr;
	commit_rec_t [COMMIT_SLOTS-1:0]        commit;
	logic [FETCH_SLOTS-1:0]                predict_taken;
	logic                                  queue_full;

	int                   chk_errors;
	int                   tb_errors = 0;
	int                   base = 0;
	int                   passed = 0;
	int                   failed = 0;
	int                   cycles = 0;
	logic                 saw_full;
	logic [31:0]          rnd;
	logic [ADDR_BITS-1:0] pool [8];

	always #10 clk = ~clk;

	gshare_predictor dut0 (
		.clk           (clk),
		.rst           (rst),
		.en            (en),
		.fetch_addr    (fetch_addr),
		.commit        (commit),
		.predict_taken (predict_taken),
		.queue_full    (queue_full)
	);

	bp_checker chk0 (
		.clk           (clk),
		.rst           (rst),
		.en            (en),
		.fetch_addr    (fetch_addr),
		.commit        (commit),
		.predict_taken (predict_taken),
		.queue_full    (queue_full),
		.errors        (chk_errors)
	);

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYC) begin
			$display("timeout: run did not finish");
			$display("Test failures found");
			$finish;
		end
	end

	function automatic commit_rec_t make_rec(input logic v, input logic t,
			input logic [ADDR_BITS-1:0] a);
		commit_rec_t r;
		r.valid = v;
		r.taken = t;
		r.addr = a;
		return r;
	endfunction

	// one cycle of inputs on the falling edge
	// commits are held back while the queue reports full
	task automatic drive_cycle(input logic e, input logic [ADDR_BITS-1:0] f0, f1,
			input commit_rec_t c0, c1);
		@(negedge clk);
		en = e;
		fetch_addr[0] = f0;
		fetch_addr[1] = f1;
		if (queue_full)
			saw_full = 1'b1;
		commit[0] = queue_full ? '0 : c0;
		commit[1] = queue_full ? '0 : c1;
	endtask

	task automatic idle_cycles(input int n, input logic [ADDR_BITS-1:0] f);
		repeat (n) drive_cycle(1'b1, f, f, '0, '0);
	endtask

	// hand derived expectation for fetch slot 0
	task automatic expect_slot0(input logic exp, input string what);
		#1;
		if (predict_taken[0] !== exp) begin
			$display("Mismatch at %0t: %s, slot 0 predicts %b, expected %b",
				$time, what, predict_taken[0], exp);
			tb_errors++;
		end
	endtask

	task automatic close_test(input int num, input string name);
		int errs;
		errs = tb_errors + chk_errors - base;
		base = tb_errors + chk_errors;
		if (errs == 0) begin
			passed++;
			$display("test %0d %s: ok", num, name);
		end else begin
			failed++;
			$display("test %0d %s: FAILED with %0d errors", num, name, errs);
		end
	endtask

	initial begin
		void'($urandom(32'h10d2));
		rst = 1'b1;
		en = 1'b0;
		fetch_addr = '0;
		commit = '0;
		saw_full = 1'b0;
		for (int i = 0; i < 8; i++)
			pool[i] = $urandom & 32'h000f_ffff;
		repeat (LEN_RESET) @(negedge clk);
		rst = 1'b0;

		// ========================================
		// directed phases
		// ========================================

		drive_cycle(1'b1, ADDR_A, ADDR_C, '0, '0);
		expect_slot0(1'b0, "untrained entry after reset");
		if (queue_full !== 1'b0) begin
			$display("Mismatch at %0t: queue_full high right after reset", $time);
			tb_errors++;
		end
		idle_cycles(4, ADDR_B);
		close_test(1, "reset state");

		// five taken outcomes bring the history to 11111
		repeat (5) drive_cycle(1'b1, ADDR_A, ADDR_A, make_rec(1'b1, 1'b1, ADDR_A), '0);
		idle_cycles(3, ADDR_A);
		expect_slot0(1'b0, "entry still weak_nt");
		drive_cycle(1'b1, ADDR_A, ADDR_A, make_rec(1'b1, 1'b1, ADDR_A), '0);
		idle_cycles(3, ADDR_A);
		expect_slot0(1'b1, "one taken update");
		repeat (2) drive_cycle(1'b1, ADDR_A, ADDR_A, make_rec(1'b1, 1'b1, ADDR_A), '0);
		// strong_t drops to weak_t, then B restores the history
		drive_cycle(1'b1, ADDR_A, ADDR_A, make_rec(1'b1, 1'b0, ADDR_A), '0);
		repeat (5) drive_cycle(1'b1, ADDR_A, ADDR_A, make_rec(1'b1, 1'b1, ADDR_B), '0);
		idle_cycles(3, ADDR_A);
		expect_slot0(1'b1, "saturated entry after one not taken");
		close_test(2, "counter training");

		// alternating outcomes train history 01010 taken and 10101 not taken
		repeat (8) begin
			drive_cycle(1'b1, ADDR_C, ADDR_C, make_rec(1'b1, 1'b1, ADDR_C), '0);
			drive_cycle(1'b1, ADDR_C, ADDR_C, make_rec(1'b1, 1'b0, ADDR_C), '0);
		end
		idle_cycles(3, ADDR_C);
		expect_slot0(1'b1, "history 01010");
		drive_cycle(1'b1, ADDR_C, ADDR_C, make_rec(1'b1, 1'b1, ADDR_C), '0);
		idle_cycles(3, ADDR_C);
		expect_slot0(1'b0, "history 10101");
		close_test(3, "history dependence");

		// two commits per cycle outrun the single retire
		saw_full = 1'b0;
		repeat (24) begin
			rnd = $urandom;
			drive_cycle(1'b1, pool[rnd[2:0]], pool[rnd[5:3]],
				make_rec(1'b1, rnd[6], pool[rnd[9:7]]),
				make_rec(1'b1, rnd[10], pool[rnd[13:11]]));
		end
		if (!saw_full) begin
			$display("queue_full never rose during a two per cycle burst");
			tb_errors++;
		end
		idle_cycles(LEN_DRAIN, ADDR_A);
		close_test(4, "dual commit bursts");

		// disabled, commits still enqueue
		repeat (6) begin
			drive_cycle(1'b0, ADDR_A, ADDR_C, make_rec(1'b1, 1'b1, ADDR_C),
				make_rec(1'b1, 1'b0, ADDR_A));
			expect_slot0(1'b0, "prediction while disabled");
		end
		idle_cycles(16, ADDR_C);
		close_test(5, "enable gating");

		// ========================================
		// random run
		// ========================================

		repeat (LEN_RAND) begin
			rnd = $urandom;
			drive_cycle(rnd[25:22] != 4'd0, pool[rnd[18:16]], pool[rnd[21:19]],
				make_rec(rnd[11:10] == 2'd0, rnd[14], pool[rnd[6:4]]),
				make_rec(rnd[13:12] == 2'd0, rnd[15], pool[rnd[9:7]]));
		end
		idle_cycles(LEN_DRAIN, ADDR_B);
		close_test(6, "random traffic");

		$display("tests passed %0d, failed %0d, errors %0d", passed, failed,
			tb_errors + chk_errors);
		if (failed == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/bp_checker.sv
`timescale 1ns/1ps
`default_nettype none

module bp_checker import bp_pkg::*; (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  en,
	input  logic [FETCH_SLOTS-1:0][ADDR_BITS-1:0] fetch_addr,
	input  commit_rec_t [COMMIT_SLOTS-1:0]        commit,
	input  logic [FETCH_SLOTS-1:0]                predict_taken,
	input  logic                                  queue_full,
	output int                                    errors
);

	// ========================================
	// reference state
	// ========================================

	commit_rec_t            model_q [$];
	logic [HIST_BITS-1:0]   model_hist;
	logic [1:0]             model_ctr [TABLE_SIZE];
	int                     err_count = 0;

	// scratch for the per edge update
	commit_rec_t            ret;
	logic [INDEX_BITS-1:0]  ui;
	logic [1:0]             c;
	logic                   exp_pred;
	logic                   exp_full;

	assign errors = err_count;

	// counters power up weakly not taken
	initial begin
		for (int i = 0; i < TABLE_SIZE; i++)
			model_ctr[i] = 2'd1;
	end

	// own copy of the hash
	// low five index bits straight from the address, upper five fold history with three chunks
	function automatic logic [INDEX_BITS-1:0] model_index(input logic [ADDR_BITS-1:0] a,
			input logic [HIST_BITS-1:0] h);
		logic [HIST_BITS-1:0] upper;
		upper = h ^ a[9:5] ^ a[14:10] ^ a[19:15];
		return {upper, a[4:0]};
	endfunction

	// ========================================
	// model step and compare
	// ========================================

	always @(posedge clk) begin
		if (rst) begin
			model_q.delete();
			model_hist = '0;
		end else begin
			// oldest entry retires first, no bypass of this edge's commits
			if (en && model_q.size() > 0) begin
				ret = model_q.pop_front();
				ui = model_index(ret.addr, model_hist);
				c = model_ctr[ui];
				if (ret.taken && c != 2'd3)
					c = c + 2'd1;
				else if (!ret.taken && c != 2'd0)
					c = c - 2'd1;
				model_ctr[ui] = c;
				model_hist = {model_hist[HIST_BITS-2:0], ret.taken};
			end
			// slot 0 lands ahead of slot 1
			for (int s = 0; s < COMMIT_SLOTS; s++) begin
				if (commit[s].valid)
					model_q.push_back(commit[s]);
			end
		end
		// let the DUT settle after the edge
		#2;
		for (int s = 0; s < FETCH_SLOTS; s++) begin
			exp_pred = en && model_ctr[model_index(fetch_addr[s], model_hist)][1];
			if (predict_taken[s] !== exp_pred) begin
				$display("Mismatch at %0t: slot %0d predict_taken %b, model %b",
					$time, s, predict_taken[s], exp_pred);
				err_count++;
			end
		end
		// full means room for less than one commit group
		exp_full = (QUEUE_DEPTH - model_q.size()) < COMMIT_SLOTS;
		if (queue_full !== exp_full) begin
			$display("Mismatch at %0t: queue_full %b, model %b", $time, queue_full, exp_full);
			err_count++;
		end
	end

endmodule

`default_nettype wire

// File: rtl/gshare_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module gshare_predictor import bp_pkg::*; (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  en,
	input  logic [FETCH_SLOTS-1:0][ADDR_BITS-1:0] fetch_addr,
	input  commit_rec_t [COMMIT_SLOTS-1:0]        commit,
	output logic [FETCH_SLOTS-1:0]                predict_taken,
	output logic                                  queue_full
);

	// ========================================
	// internal nets
	// ========================================

	// queue to updater
	commit_rec_t          head;
	logic                 pop;
	// updater to table
	logic [HIST_BITS-1:0] history;
	table_idx_t           upd_idx;
	ctr_state_e           upd_state;
	logic                 wr_en;
	table_idx_t           wr_idx;
	ctr_state_e           wr_state;

	// resolved branches wait here until retired
	resolve_queue u_queue (
		.clk    (clk),
		.rst    (rst),
		.commit (commit),
		.pop    (pop),
		.head   (head),
		.full   (queue_full)
	);

	// retire path, one branch per cycle
	counter_update u_update (
		.clk       (clk),
		.rst       (rst),
		.en        (en),
		.head      (head),
		.pop       (pop),
		.history   (history),
		.upd_idx   (upd_idx),
		.upd_state (upd_state),
		.wr_en     (wr_en),
		.wr_idx    (wr_idx),
		.wr_state  (wr_state)
	);

	// counters, fetch lookup and update port
	pattern_table u_table (
		.clk           (clk),
		.fetch_addr    (fetch_addr),
		.history       (history),
		.en            (en),
		.predict_taken (predict_taken),
		.upd_idx       (upd_idx),
		.upd_state     (upd_state),
		.wr_en         (wr_en),
		.wr_idx        (wr_idx),
		.wr_state      (wr_state)
	);

endmodule

`default_nettype wire

// File: rtl/counter_update.sv
`timescale 1ns/1ps
`default_nettype none

module counter_update import bp_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 en,
	input  commit_rec_t          head,
	output logic                 pop,
	output logic [HIST_BITS-1:0] history,
	output table_idx_t           upd_idx,
	input  ctr_state_e           upd_state,
	output logic                 wr_en,
	output table_idx_t           wr_idx,
	output ctr_state_e           wr_state
);

	// saturating next value of the head branch's counter
	ctr_state_e next_state;

	// head index uses the history as it stands before this retire
	assign upd_idx = gshare_index(head.addr, history);

	// one retire per cycle, frozen while disabled
	assign pop = en && head.valid;
	assign wr_en = pop;
	assign wr_idx = upd_idx;
	assign wr_state = next_state;

	// ========================================
	// two bit saturating counter
	// ========================================

	always_comb begin
		unique case (upd_state)
			strong_nt: next_state = head.taken ? weak_nt : strong_nt;
			weak_nt:   next_state = head.taken ? weak_t : strong_nt;
			weak_t:    next_state = head.taken ? strong_t : weak_nt;
			strong_t:  next_state = head.taken ? strong_t : weak_t;
			default:   next_state = weak_nt;
		endcase
	end

	// ========================================
	// global history
	// ========================================

	// newest outcome enters at bit 0, same edge as the table write
	always_ff @(posedge clk) begin
		if (rst)
			history <= '0;
		else if (wr_en)
			history <= {history[HIST_BITS-2:0], head.taken};
	end

	// a retire moves its counter toward the outcome
	// and only stays put at the saturated end
	a_wr_from_head: assert property (@(posedge clk) disable iff (rst)
		wr_en |-> (head.taken ? (wr_state >= upd_state) : (wr_state <= upd_state))
			&& ((wr_state != upd_state)
				|| (upd_state == (head.taken ? strong_t : strong_nt))))
		else $error("counter_update: counter write does not follow the branch outcome");

endmodule

`default_nettype wire

// File: rtl/pattern_table.sv
`timescale 1ns/1ps
`default_nettype none

module pattern_table import bp_pkg::*; (
	input  logic                                  clk,
	input  logic [FETCH_SLOTS-1:0][ADDR_BITS-1:0] fetch_addr,
	input  logic [HIST_BITS-1:0]                  history,
	input  logic                                  en,
	output logic [FETCH_SLOTS-1:0]                predict_taken,
	input  table_idx_t                            upd_idx,
	output ctr_state_e                            upd_state,
	input  logic                                  wr_en,
	input  table_idx_t                            wr_idx,
	input  ctr_state_e                            wr_state
);

	// ========================================
	// counter array
	// ========================================

	// distributed style memory, async reads
	ctr_state_e ctr_mem [TABLE_SIZE];

	// per slot hashed index and the counter it selects
	table_idx_t fetch_idx [FETCH_SLOTS];
	ctr_state_e fetch_state [FETCH_SLOTS];

	// every counter starts weakly not taken
	// reset leaves the table alone
	initial begin
		for (int i = 0; i < TABLE_SIZE; i++)
			ctr_mem[i] = weak_nt;
	end

	// ========================================
	// fetch lookup
	// ========================================

	// same cycle prediction from current history
	always_comb begin
		for (int s = 0; s < FETCH_SLOTS; s++) begin
			fetch_idx[s] = gshare_index(fetch_addr[s], history);
			fetch_state[s] = ctr_mem[fetch_idx[s]];
			// weak_t and strong_t both have the msb set
			predict_taken[s] = en && fetch_state[s][1];
		end
	end

	// ========================================
	// update side
	// ========================================

	// read port for the updater, current value before this edge's write
	assign upd_state = ctr_mem[upd_idx];

	// single write port
	always @(posedge clk) begin
		if (wr_en)
			ctr_mem[wr_idx] <= wr_state;
	end

endmodule

`default_nettype wire

// File: rtl/resolve_queue.sv
`timescale 1ns/1ps
`default_nettype none

module resolve_queue import bp_pkg::*; (
	input  logic                           clk,
	input  logic                           rst,
	input  commit_rec_t [COMMIT_SLOTS-1:0] commit,
	input  logic                           pop,
	output commit_rec_t                    head,
	output logic                           full
);

	// pointers carry one extra wrap bit
	logic [QPTR_BITS:0] wr_ptr;
	logic [QPTR_BITS:0] rd_ptr;
	logic [QPTR_BITS:0] used;
	logic [QPTR_BITS:0] free_cnt;
	logic [QPTR_BITS:0] n_valid;
	logic [QPTR_BITS:0] slot_ptr [COMMIT_SLOTS];
	logic               empty;

	// entry storage, payload only so no reset
	commit_rec_t mem [QUEUE_DEPTH];

	assign used = wr_ptr - rd_ptr;
	assign free_cnt = (QPTR_BITS+1)'(QUEUE_DEPTH) - used;
	assign empty = (used == '0);
	// must leave room for a full commit group
	assign full = (free_cnt < (QPTR_BITS+1)'(COMMIT_SLOTS));

	// ========================================
	// compaction of commit slots
	// ========================================

	// each valid slot lands after the valid slots before it
	always_comb begin
		n_valid = '0;
		for (int s = 0; s < COMMIT_SLOTS; s++) begin
			slot_ptr[s] = wr_ptr + n_valid;
			n_valid = n_valid + (QPTR_BITS+1)'(commit[s].valid);
		end
	end

	always_ff @(posedge clk) begin
		for (int s = 0; s < COMMIT_SLOTS; s++) begin
			if (commit[s].valid)
				mem[slot_ptr[s][QPTR_BITS-1:0]] <= commit[s];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			wr_ptr <= wr_ptr + n_valid;
			// head moves only when something is there
			if (pop && !empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// oldest entry, valid low when nothing queued
	assign head = empty ? '0 : mem[rd_ptr[QPTR_BITS-1:0]];

	// commit side has to honour full
	a_no_write_full: assert property (@(posedge clk) disable iff (rst)
		full |-> !(|{commit[1].valid, commit[0].valid}))
		else $error("resolve_queue: commit presented while full");

	// updater only pops a valid head
	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
		pop |-> !empty)
		else $error("resolve_queue: pop while empty");

endmodule

`default_nettype wire

// File: rtl/bp_pkg.sv
`default_nettype none

package bp_pkg;

	// ========================================
	// sizes
	// ========================================

	// instruction address width
	localparam int ADDR_BITS = 32;
	// global history length, also the width of the hashed index field
	localparam int HIST_BITS = 5;
	// address bits used directly as the low index field
	localparam int LOW_BITS = 5;
	localparam int INDEX_BITS = HIST_BITS + LOW_BITS;
	localparam int TABLE_SIZE = 1 << INDEX_BITS;

	// superscalar widths
	localparam int FETCH_SLOTS = 2;
	localparam int COMMIT_SLOTS = 2;

	// resolve queue, depth must stay a power of two
	localparam int QUEUE_DEPTH = 16;
	localparam int QPTR_BITS = $clog2(QUEUE_DEPTH);

	// ========================================
	// types
	// ========================================

	// two bit saturating counter, msb set means predict taken
	typedef enum logic [1:0] {
		strong_nt = 2'd0,
		weak_nt   = 2'd1,
		weak_t    = 2'd2,
		strong_t  = 2'd3
	} ctr_state_e;

	// one resolved branch from commit
	typedef struct packed {
		logic                 valid;
		logic                 taken;
		logic [ADDR_BITS-1:0] addr;
	} commit_rec_t;

	// table index, hashed field on top
	typedef struct packed {
		logic [HIST_BITS-1:0] hashed;
		logic [LOW_BITS-1:0]  low;
	} table_idx_t;

	// gshare hash shared by fetch lookup and update
	// low field is straight address, upper field folds three address chunks with history
	function automatic table_idx_t gshare_index(input logic [ADDR_BITS-1:0] addr,
			input logic [HIST_BITS-1:0] hist);
		table_idx_t idx;
		idx.low = addr[LOW_BITS-1:0];
		idx.hashed = hist
			^ addr[LOW_BITS +: HIST_BITS]
			^ addr[LOW_BITS + HIST_BITS +: HIST_BITS]
			^ addr[LOW_BITS + 2*HIST_BITS +: HIST_BITS];
		return idx;
	endfunction

endpackage

`default_nettype wire
